/* design/frame_sequencer.sv */
`include "video_consts.svh"

module frame_sequencer (
    input  logic                   m_axi4s,
    input  logic                   rst,
    input  video_pkg::frame_cmd_t  cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output video_pkg::frame_cmd_t  cfg,
    output logic [`VID_F_BITS-1:0] frame_index,
    output logic                   run,
    output logic                   busy,
    output logic [`VID_F_BITS-1:0] frame_count,
    input  logic                   frame_end
);
    localparam int F_BITS = `VID_F_BITS;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        RUN
    } state_e;

    state_e              state;
    logic [F_BITS-1:0]   remaining;             // frames left in the current command.
    logic                cmd_fire;

    assign cmd_ready = (state == IDLE);         // a new command waits in the slice otherwise.
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign run       = (state == RUN);
    assign busy      = (state != IDLE);

    // LOAD holds the raster counter cleared for one cycle while cfg settles.
    always_ff @(posedge m_axi4s) begin
        if (rst) begin
            state       <= IDLE;
            remaining   <= '0;
            frame_index <= '0;
            frame_count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_fire) begin
                        state       <= LOAD;
                        frame_index <= '0;      // the ramp restarts per command.
                        if (cmd.frames == '0) begin
                            remaining <= F_BITS'(1);
                        end else begin
                            remaining <= cmd.frames;
                        end
                    end
                end
                LOAD: begin
                    state <= RUN;
                end
                RUN: begin
                    if (frame_end) begin
                        remaining   <= remaining - F_BITS'(1);
                        frame_index <= frame_index + F_BITS'(1);
                        frame_count <= frame_count + F_BITS'(1);
                        if (remaining == F_BITS'(1)) begin
                            state <= IDLE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge m_axi4s) begin
        if (cmd_fire) begin
            cfg <= cmd;
        end
    end

endmodule

/* design/pattern_source.sv */
`include "video_consts.svh"

module pattern_source (
    input  logic                      m_axi4s,
    input  logic                      rst,
    input  video_pkg::raster_pos_t    pos,
    input  logic                      pos_valid,
    input  video_pkg::pattern_mode_e  mode,
    input  video_pkg::pixel_t         color,
    input  logic [`VID_F_BITS-1:0]    frame_index,
    input  logic                      out_ready,
    output logic                      advance,
    output video_pkg::pixel_beat_t    beat,
    output logic                      out_valid
);
    import video_pkg::*;

    localparam int CELL = `VID_CELL_LOG2;
    localparam int DW   = `VID_DATA_BITS;

    pixel_t pixel;
    logic   take;
    logic   cell_odd;

    // The output register can be written when it is empty or draining this cycle.
    assign take    = !out_valid || out_ready;
    assign advance = pos_valid && take;

    // Neighbouring cells alternate in both directions.
    assign cell_odd = pos.x[CELL] ^ pos.y[CELL];

    always_comb begin
        case (mode)
            PAT_SOLID: begin
                pixel = color;
            end
            PAT_CHECKER: begin
                pixel = cell_odd ? ~color : color;
            end
            default: begin
                pixel[0] = pos.x[DW-1:0];       // ramp, cut to the low bits.
                pixel[1] = pos.y[DW-1:0];
                pixel[2] = frame_index[DW-1:0];
            end
        endcase
    end

    always_ff @(posedge m_axi4s) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= pos_valid && pos.active;   // blanking makes no beat.
        end
    end

    always_ff @(posedge m_axi4s) begin
        if (advance && pos.active) begin
            beat.data <= pixel;
            beat.user <= pos.sof;
            beat.last <= pos.eol;
        end
    end

endmodule

/* design/raster_counter.sv */
`include "video_consts.svh"

module raster_counter (
    input  logic                     m_axi4s,
    input  logic                     rst,
    input  logic                     run,
    input  video_pkg::frame_cmd_t    cfg,
    input  logic                     advance,
    output video_pkg::raster_pos_t   pos,
    output logic                     pos_valid,
    output logic                     frame_end
);
    logic [`VID_X_BITS-1:0] x;
    logic [`VID_Y_BITS-1:0] y;
    logic [`VID_X_BITS-1:0] h_total;
    logic [`VID_Y_BITS-1:0] v_total;
    logic                   x_wrap;
    logic                   y_wrap;
    logic                   active;

    assign h_total = cfg.width + cfg.h_blank;
    assign v_total = cfg.height + cfg.v_blank;
    assign x_wrap  = (x == h_total - 1'b1);     // last column, blanking included.
    assign y_wrap  = (y == v_total - 1'b1);
    assign active  = (x < cfg.width) && (y < cfg.height);

    // The position is presented straight from the counter registers.
    always_comb begin
        pos.x      = x;
        pos.y      = y;
        pos.active = active;
        pos.sof    = active && (x == '0) && (y == '0);
        pos.eol    = active && (x == cfg.width - 1'b1);
        pos.last   = x_wrap && y_wrap;
    end

    assign pos_valid = run;
    assign frame_end = pos_valid && advance && pos.last;

    // The counter wraps to (0,0) by itself, so frames of one command run back to back.
    always_ff @(posedge m_axi4s) begin
        if (rst || !run) begin
            x <= '0;
            y <= '0;
        end else if (advance) begin
            if (x_wrap) begin
                x <= '0;
                if (y_wrap) begin
                    y <= '0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;                  // frozen while advance is low.
            end
        end
    end

endmodule

/* design/stream_reg_slice.sv */
module stream_reg_slice #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     m_axi4s,
    input  logic     rst,
    input  payload_t s_data,
    input  logic     s_valid,
    output logic     s_ready,
    output payload_t m_data,
    output logic     m_valid,
    input  logic     m_ready
);
    payload_t skid_data;
    logic     skid_valid;
    logic     s_fire;
    logic     main_free;
    logic     skid_next;

    assign s_fire    = s_valid && s_ready;
    assign main_free = !m_valid || m_ready;     // main register empty or draining.

    // The skid entry fills only when a beat arrives while the output is stalled.
    always_comb begin
        if (main_free) begin
            skid_next = 1'b0;
        end else begin
            skid_next = skid_valid || s_fire;
        end
    end

    always_ff @(posedge m_axi4s) begin
        if (rst) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
            s_ready    <= 1'b0;
        end else begin
            skid_valid <= skid_next;
            s_ready    <= !skid_next;           // registered, so no path from m_ready.
            if (main_free) begin
                m_valid <= skid_valid || s_fire;
            end
        end
    end

    always_ff @(posedge m_axi4s) begin
        if (main_free) begin
            if (skid_valid) begin
                m_data <= skid_data;            // the older beat leaves first.
            end else begin
                m_data <= s_data;
            end
        end
        if (!main_free && s_fire) begin
            skid_data <= s_data;
        end
    end

endmodule

/* design/video_consts.svh */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Coordinate and size widths. They also bound the largest raster with blanking.
`define VID_X_BITS 12
`define VID_Y_BITS 12

// Width of the frame counters.
`define VID_F_BITS 16

// Pixel format: three components of eight bits each.
`define VID_DATA_BITS 8
`define VID_COMPONENTS 3

// Width of the pattern mode code.
`define VID_MODE_BITS 2

// Checkerboard cells are 2**VID_CELL_LOG2 pixels on each side.
`define VID_CELL_LOG2 3

`endif

/* design/video_pkg.sv */
`include "video_consts.svh"

package video_pkg;

    // Pattern modes. The unused fourth code falls back to the ramp.
    typedef enum logic [`VID_MODE_BITS-1:0] {
        PAT_RAMP    = 2'd0,
        PAT_SOLID   = 2'd1,
        PAT_CHECKER = 2'd2
    } pattern_mode_e;

    // Component 0 sits in the low byte of tdata.
    typedef logic [`VID_COMPONENTS-1:0][`VID_DATA_BITS-1:0] pixel_t;

    typedef struct packed {
        logic [`VID_X_BITS-1:0] width;
        logic [`VID_Y_BITS-1:0] height;
        logic [`VID_X_BITS-1:0] h_blank;
        logic [`VID_Y_BITS-1:0] v_blank;
        pattern_mode_e          mode;
        pixel_t                 color;
        logic [`VID_F_BITS-1:0] frames;     // a value of zero runs one frame.
    } frame_cmd_t;

    typedef struct packed {
        logic [`VID_X_BITS-1:0] x;
        logic [`VID_Y_BITS-1:0] y;
        logic                   active;     // inside the visible area.
        logic                   sof;        // first visible pixel of the frame.
        logic                   eol;        // last visible pixel of a line.
        logic                   last;       // final position including blanking.
    } raster_pos_t;

    typedef struct packed {
        pixel_t data;
        logic   user;                       // start of frame, as on tuser.
        logic   last;                       // end of line, as on tlast.
    } pixel_beat_t;

endpackage

/* design/video_stream_gen.sv */
`include "video_consts.svh"

module video_stream_gen (
    input  logic                     m_axi4s,
    input  logic                     rst,
    input  video_pkg::frame_cmd_t    cmd,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    output video_pkg::pixel_beat_t   m_axis,
    output logic                     m_axis_valid,
    input  logic                     m_axis_ready,
    output logic                     busy,
    output logic [`VID_F_BITS-1:0]   frame_count
);
    import video_pkg::*;

    frame_cmd_t             slice_cmd;
    logic                   slice_cmd_valid;
    logic                   seq_cmd_ready;
    frame_cmd_t             cfg;
    logic [`VID_F_BITS-1:0] frame_index;
    logic                   run;
    logic                   frame_end;
    raster_pos_t            pos;
    logic                   pos_valid;
    logic                   advance;
    pixel_beat_t            beat;
    logic                   beat_valid;
    logic                   beat_ready;

    // Command input slice. A second command can wait here while a frame runs.
    stream_reg_slice #(
        .payload_t(frame_cmd_t)
    ) cmd_slice_i (
        .m_axi4s(m_axi4s),
        .rst    (rst),
        .s_data (cmd),
        .s_valid(cmd_valid),
        .s_ready(cmd_ready),
        .m_data (slice_cmd),
        .m_valid(slice_cmd_valid),
        .m_ready(seq_cmd_ready)
    );

    frame_sequencer frame_sequencer_i (
        .m_axi4s    (m_axi4s),
        .rst        (rst),
        .cmd        (slice_cmd),
        .cmd_valid  (slice_cmd_valid),
        .cmd_ready  (seq_cmd_ready),
        .cfg        (cfg),
        .frame_index(frame_index),
        .run        (run),
        .busy       (busy),
        .frame_count(frame_count),
        .frame_end  (frame_end)
    );

    raster_counter raster_counter_i (
        .m_axi4s  (m_axi4s),
        .rst      (rst),
        .run      (run),
        .cfg      (cfg),
        .advance  (advance),
        .pos      (pos),
        .pos_valid(pos_valid),
        .frame_end(frame_end)
    );

    pattern_source pattern_source_i (
        .m_axi4s    (m_axi4s),
        .rst        (rst),
        .pos        (pos),
        .pos_valid  (pos_valid),
        .mode       (cfg.mode),
        .color      (cfg.color),
        .frame_index(frame_index),
        .out_ready  (beat_ready),
        .advance    (advance),
        .beat       (beat),
        .out_valid  (beat_valid)
    );

    // Output slice. Its registered ready keeps m_axis_ready off the raster path.
    stream_reg_slice #(
        .payload_t(pixel_beat_t)
    ) beat_slice_i (
        .m_axi4s(m_axi4s),
        .rst    (rst),
        .s_data (beat),
        .s_valid(beat_valid),
        .s_ready(beat_ready),
        .m_data (m_axis),
        .m_valid(m_axis_valid),
        .m_ready(m_axis_ready)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the video stream generator testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module video_stream_gen_tb \
    -f sources.f

./obj_dir/Vvideo_stream_gen_tb | tee sim.log

if grep -q "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

/* sources.f */
+incdir+design
design/video_pkg.sv
design/stream_reg_slice.sv
design/frame_sequencer.sv
design/raster_counter.sv
design/pattern_source.sv
design/video_stream_gen.sv
test/video_stream_gen_checker.sv
test/video_stream_gen_tb.sv

/* test/frame_cases.txt */
# width height h_blank v_blank mode color frames stall% beats frame_count wait_idle
# decimal fields except color (hex); mode 0 ramp, 1 solid, 2 checker
16 4 4 2 0 000000 1 0 64 1 1
10 3 2 1 0 000000 3 0 90 4 1
12 2 3 0 1 12ab34 1 0 24 5 1
24 17 4 3 2 a05f3c 1 0 408 6 1
20 5 3 2 0 000000 2 40 200 8 1
8 4 2 1 0 000000 2 25 64 10 0
16 16 0 0 2 0f0f0f 1 30 256 11 1
9 2 1 1 0 000000 0 10 18 12 1
300 1 0 0 0 000000 1 20 300 13 1

/* test/video_stream_gen_checker.sv */
`include "video_consts.svh"

module video_stream_gen_checker (
    input logic                   m_axi4s,
    input logic                   rst,
    input video_pkg::frame_cmd_t  cmd,
    input logic                   cmd_valid,
    input logic                   cmd_ready,
    input video_pkg::pixel_beat_t m_axis,
    input logic                   m_axis_valid,
    input logic                   m_axis_ready,
    input logic [`VID_X_BITS-1:0] width
);
    import video_pkg::*;

    timeunit 1ns;
    timeprecision 1ps;

    // A stalled output beat must wait unchanged.
    assert property (@(posedge m_axi4s) disable iff (rst)
        m_axis_valid && !m_axis_ready |=> m_axis_valid && $stable(m_axis))
    else $error("m_axis changed while stalled");

    // The command source holds its request until it is taken.
    assert property (@(posedge m_axi4s) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
    else $error("cmd changed while waiting for cmd_ready");

    // Checked one cycle into reset, once the registers have been cleared.
    assert property (@(posedge m_axi4s)
        rst |=> !rst || !m_axis_valid)
    else $error("m_axis_valid high during reset");

    // Start of frame and end of line coincide only on a one pixel wide image.
    assert property (@(posedge m_axi4s) disable iff (rst)
        m_axis_valid && m_axis.user && m_axis.last |-> width == `VID_X_BITS'(1))
    else $error("user and last on the same beat");

endmodule

bind video_stream_gen video_stream_gen_checker checker_i (
    .m_axi4s     (m_axi4s),
    .rst         (rst),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .m_axis      (m_axis),
    .m_axis_valid(m_axis_valid),
    .m_axis_ready(m_axis_ready),
    .width       (cfg.width)
);

/* test/video_stream_gen_tb.sv */
`include "video_consts.svh"

module video_stream_gen_tb;
    import video_pkg::*;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CASES = 32;

    logic                   m_axi4s;
    logic                   rst;
    frame_cmd_t             cmd;
    logic                   cmd_valid;
    logic                   cmd_ready;
    pixel_beat_t            m_axis;
    logic                   m_axis_valid;
    logic                   m_axis_ready;
    logic                   busy;
    logic [`VID_F_BITS-1:0] frame_count;

    frame_cmd_t  case_cmd[MAX_CASES];
    int          case_stall[MAX_CASES];
    int          case_beats[MAX_CASES];
    int          case_count[MAX_CASES];
    int          case_wait[MAX_CASES];
    int          n_cases;
    pixel_beat_t exp_q[$];
    int          beats_seen;
    int          stall_pct;
    int          cycle_limit;
    int          cycles;
    logic [31:0] lfsr;

    video_stream_gen video_stream_gen_i (
        .m_axi4s     (m_axi4s),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .m_axis      (m_axis),
        .m_axis_valid(m_axis_valid),
        .m_axis_ready(m_axis_ready),
        .busy        (busy),
        .frame_count (frame_count)
    );

    initial begin
        m_axi4s = 1'b0;
        forever begin
            #2 m_axi4s = ~m_axi4s;
        end
    end

    task automatic fail_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_beat(input pixel_beat_t got, input pixel_beat_t exp);
        if (got !== exp) begin
            $display("ERR m_axis got %h expected %h", got, exp);
            fail_run();
        end
    endtask

    task automatic check_count(input logic [`VID_F_BITS-1:0] got,
                               input logic [`VID_F_BITS-1:0] exp);
        if (got !== exp) begin
            $display("ERR frame_count got %h expected %h", got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic read_cases();
        int    fd;
        int    w, h, hb, vb, m, col, fr, st, bt, fc, wt;
        int    n;
        string line;
        longint total;
        fd = $fopen("test/frame_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file test/frame_cases.txt");
            fail_run();
        end
        n_cases = 0;
        total = 0;
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;                           // comment or empty line.
            end
            n = $sscanf(line, "%d %d %d %d %d %h %d %d %d %d %d",
                        w, h, hb, vb, m, col, fr, st, bt, fc, wt);
            if (n != 11) begin
                $display("malformed line in the case file: %s", line);
                fail_run();
            end
            case_cmd[n_cases].width   = `VID_X_BITS'(w);
            case_cmd[n_cases].height  = `VID_Y_BITS'(h);
            case_cmd[n_cases].h_blank = `VID_X_BITS'(hb);
            case_cmd[n_cases].v_blank = `VID_Y_BITS'(vb);
            case_cmd[n_cases].mode    = pattern_mode_e'(m[1:0]);
            case_cmd[n_cases].color   = pixel_t'(col[23:0]);
            case_cmd[n_cases].frames  = `VID_F_BITS'(fr);
            case_stall[n_cases] = st;
            case_beats[n_cases] = bt;
            case_count[n_cases] = fc;
            case_wait[n_cases]  = wt;
            total += longint'((fr == 0) ? 1 : fr) * (w + hb) * (h + vb);
            n_cases++;
        end
        $fclose(fd);
        cycle_limit = int'(total * 4) + 1000;
    endtask

    // Reference model: pushes every beat the command should produce.
    task automatic queue_expected(input frame_cmd_t c, output int count);
        int          frames;
        pixel_beat_t b;
        logic        odd;
        frames = (c.frames == 0) ? 1 : int'(c.frames);
        count = 0;
        for (int f = 0; f < frames; f++) begin
            for (int y = 0; y < int'(c.height); y++) begin
                for (int x = 0; x < int'(c.width); x++) begin
                    odd = ((x >> `VID_CELL_LOG2) & 1) != ((y >> `VID_CELL_LOG2) & 1);
                    if (c.mode == PAT_SOLID) begin
                        b.data = c.color;
                    end else if (c.mode == PAT_CHECKER) begin
                        b.data = odd ? ~c.color : c.color;
                    end else begin
                        b.data[0] = 8'(x);
                        b.data[1] = 8'(y);
                        b.data[2] = 8'(f);
                    end
                    b.user = (x == 0) && (y == 0);
                    b.last = (x == int'(c.width) - 1);
                    exp_q.push_back(b);
                    count++;
                end
            end
        end
    endtask

    task automatic send_command(input frame_cmd_t c);
        logic accepted;
        @(posedge m_axi4s);
        #1;
        cmd       = c;
        cmd_valid = 1'b1;
        do begin
            @(negedge m_axi4s);
            accepted = cmd_ready;
            @(posedge m_axi4s);
        end while (!accepted);
        #1;
        cmd_valid = 1'b0;
    endtask

    // Output back-pressure, one ready decision per cycle.
    initial begin
        int val;
        m_axis_ready = 1'b0;
        lfsr = 32'hde17;
        forever begin
            @(posedge m_axi4s);
            #1;
            val = 0;
            for (int i = 0; i < 7; i++) begin
                lfsr = lfsr_step(lfsr);
                val = (val << 1) | int'(lfsr[0]);
            end
            m_axis_ready = !rst && ((val % 100) >= stall_pct);
        end
    end

    // Beat monitor. Values are taken at the falling edge where they are stable.
    initial begin
        pixel_beat_t exp;
        beats_seen = 0;
        forever begin
            @(negedge m_axi4s);
            if (!rst && m_axis_valid && m_axis_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a beat arrived that the model does not expect");
                    fail_run();
                end
                exp = exp_q.pop_front();
                check_beat(m_axis, exp);
                beats_seen++;
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge m_axi4s);
            cycles++;
            if (cycle_limit != 0 && cycles >= cycle_limit) begin
                $display("timeout after %0d cycles, the stream did not complete", cycles);
                fail_run();
            end
        end
    end

    initial begin
        int   cum_beats;
        int   n;
        logic saw_busy;
        rst         = 1'b1;
        cmd         = '0;
        cmd_valid   = 1'b0;
        stall_pct   = 0;
        cycle_limit = 0;
        read_cases();
        repeat (10) @(posedge m_axi4s);
        #1;
        rst = 1'b0;
        @(negedge m_axi4s);
        check_flag("cmd_ready", cmd_ready, 1'b0);
        check_flag("m_axis_valid", m_axis_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_count(frame_count, '0);
        @(negedge m_axi4s);
        check_flag("cmd_ready", cmd_ready, 1'b1);   // one cycle after reset ends.

        cum_beats = 0;
        for (int i = 0; i < n_cases; i++) begin
            queue_expected(case_cmd[i], n);
            if (n != case_beats[i]) begin
                $display("case %0d: model gives %0d beats, the case file says %0d",
                         i, n, case_beats[i]);
                fail_run();
            end
            cum_beats += n;
            stall_pct = case_stall[i];
            send_command(case_cmd[i]);
            if (case_wait[i] != 0) begin
                saw_busy = 1'b0;
                do begin
                    @(negedge m_axi4s);
                    saw_busy = saw_busy | busy;
                end while (beats_seen != cum_beats || busy);
                check_flag("busy", saw_busy, 1'b1);   // a running command shows as busy.
                check_count(frame_count, `VID_F_BITS'(case_count[i]));
            end
        end

        // Any stray beat would show up in the monitor during this drain.
        stall_pct = 0;
        repeat (50) @(posedge m_axi4s);
        if (exp_q.size() == 0 && beats_seen == cum_beats) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d expected beats never arrived", exp_q.size());
            fail_run();
        end
    end

endmodule
